// File: cpuPkg.sv
package cpuPkg;

	// Datapath sizes
	localparam int DataWidth = 16;
	localparam int RegAddrWidth = 4;

	typedef logic [DataWidth-1:0] word_t;
	typedef logic [RegAddrWidth-1:0] regAddr_t;

	// Opcode field, unlisted codes decode as NOP
	typedef enum logic [3:0] {
		OpAdd = 4'd0,
		OpSub = 4'd1,
		OpXor = 4'd2,
		OpLw  = 4'd8,
		OpSw  = 4'd9,
		OpLlb = 4'd10,
		OpLhb = 4'd11,
		OpB   = 4'd12,
		OpHlt = 4'd15
	} opcode_e;

	// Branch condition in instr[11:9]
	typedef enum logic [2:0] {
		CondNe,
		CondEq,
		CondGt,
		CondLt,
		CondGe,
		CondLe,
		CondOv,
		CondAlways
	} cond_e;

	typedef enum logic [1:0] {
		AluAdd,
		AluSub,
		AluXor,
		AluByte
	} aluOp_e;

	// Source of an EX operand
	typedef enum logic [1:0] {
		FwdNone,
		FwdMem,
		FwdWb
	} fwdSel_e;

	typedef struct packed {
		logic n;
		logic v;
		logic z;
	} flags_t;

	// All zero is a bubble
	typedef struct packed {
		logic   regWrite;
		logic   memRead;
		logic   memWrite;
		logic   setsFlags;
		aluOp_e aluOp;
		logic   loadHigh;
		logic   hlt;
	} ctrl_t;

	typedef struct packed {
		word_t instr;
		word_t pcPlus1;
	} ifId_t;

	typedef struct packed {
		ctrl_t    ctrl;
		word_t    opA;
		word_t    opB;
		regAddr_t srcA;
		regAddr_t srcB;
		regAddr_t dst;
		word_t    imm;
	} idEx_t;

	typedef struct packed {
		ctrl_t    ctrl;
		word_t    aluResult;
		word_t    storeData;
		regAddr_t dst;
	} exMem_t;

	typedef struct packed {
		logic     regWrite;
		logic     hlt;
		logic     memRead;
		word_t    aluResult;
		word_t    readData;
		regAddr_t dst;
	} memWb_t;

	// APB master outputs
	typedef struct packed {
		logic  psel;
		logic  penable;
		logic  pwrite;
		word_t paddr;
		word_t pwdata;
	} apbReq_t;

	// APB slave response
	typedef struct packed {
		word_t prdata;
		logic  pready;
	} apbRsp_t;

endpackage

// File: pipeReg.sv
`timescale 1ns/1ps

module pipeReg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rstN,
	input  logic     en,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// Flush only takes effect on an enabled cycle
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			q <= '0;
		end else if (en) begin
			if (flush) begin
				q <= '0;
			end else begin
				q <= d;
			end
		end
	end

	// Upstream stages never hand over X once out of reset
	qKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(q));

endmodule

// File: fetchStage.sv
`timescale 1ns/1ps

module fetchStage import cpuPkg::*; #(
	parameter word_t ResetPc = '0
) (
	input  logic  clk,
	input  logic  rstN,
	input  word_t instr,
	output word_t pc,
	input  logic  branchTaken,
	input  word_t branchTarget,
	input  logic  hazardStall,
	input  logic  memStall,
	input  logic  haltSeen,
	output ifId_t ifId
);

	// Sticky once HLT has been decoded
	logic halted;
	ifId_t ifIdNext;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= ResetPc;
			halted <= 1'b0;
		end else if (!memStall) begin
			if (haltSeen) begin
				halted <= 1'b1;
			end
			// Branch wins, stalls and halt hold the pc
			if (branchTaken) begin
				pc <= branchTarget;
			end else if (!hazardStall && !haltSeen && !halted) begin
				pc <= pc + 1'b1;
			end
		end
	end

	assign ifIdNext = '{instr: instr, pcPlus1: pc + 1'b1};

	// Wrong-path word dropped on branch, nothing new after HLT
	pipeReg #(.payload_t(ifId_t)) u_ifIdReg (
		.clk  (clk),
		.rstN (rstN),
		.en   (!(memStall || hazardStall)),
		.flush(branchTaken || haltSeen || halted),
		.d    (ifIdNext),
		.q    (ifId)
	);

endmodule

// File: decodeStage.sv
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  ifId_t    ifId,
	input  flags_t   flags,
	input  logic     hazardStall,
	input  logic     memStall,
	input  logic     wbEn,
	input  regAddr_t wbReg,
	input  word_t    wbData,
	output regAddr_t srcA,
	output regAddr_t srcB,
	output logic     isBranch,
	output logic     branchTaken,
	output word_t    branchTarget,
	output logic     haltSeen,
	output idEx_t    idEx
);

	word_t regFile [1:2**RegAddrWidth-1];
	opcode_e op;
	regAddr_t dst;
	ctrl_t ctrl;
	word_t imm;
	logic condTrue;
	idEx_t idExNext;

	assign op = opcode_e'(ifId.instr[15:12]);
	assign dst = ifId.instr[11:8];

	// Register file, r0 has no storage
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 1; i < 2**RegAddrWidth; i++) begin
				regFile[i] <= '0;
			end
		end else if (wbEn && wbReg != '0) begin
			regFile[wbReg] <= wbData;
		end
	end

	// Read with same-cycle writeback bypass
	function automatic word_t readReg(regAddr_t addr);
		word_t value;
		if (addr == '0) begin
			value = '0;
		end else if (wbEn && wbReg == addr) begin
			value = wbData;
		end else begin
			value = regFile[addr];
		end
		return value;
	endfunction

	// Control decode
	// Unused sources stay at r0 so they never stall or forward
	always_comb begin
		ctrl = '0;
		srcA = '0;
		srcB = '0;
		imm = '0;
		// All-zero word is the flush pattern, treated as NOP
		if (ifId.instr != '0) begin
			case (op)
				OpAdd, OpSub, OpXor: begin
					ctrl.regWrite = 1'b1;
					ctrl.setsFlags = 1'b1;
					ctrl.aluOp = (op == OpAdd) ? AluAdd : (op == OpSub) ? AluSub : AluXor;
					srcA = ifId.instr[7:4];
					srcB = ifId.instr[3:0];
				end
				OpLw, OpSw: begin
					ctrl.regWrite = (op == OpLw);
					ctrl.memRead = (op == OpLw);
					ctrl.memWrite = (op == OpSw);
					ctrl.aluOp = AluAdd;
					srcA = ifId.instr[7:4];
					// Store data comes from the rd field
					srcB = (op == OpSw) ? ifId.instr[11:8] : '0;
					imm = {{(DataWidth-4){ifId.instr[3]}}, ifId.instr[3:0]};
				end
				OpLlb, OpLhb: begin
					ctrl.regWrite = 1'b1;
					ctrl.aluOp = AluByte;
					ctrl.loadHigh = (op == OpLhb);
					// Old rd value keeps the other byte
					srcB = ifId.instr[11:8];
					imm = {{(DataWidth-8){ifId.instr[7]}}, ifId.instr[7:0]};
				end
				OpHlt: ctrl.hlt = 1'b1;
				default: ctrl = '0;
			endcase
		end
		// Writes to r0 are discarded here
		ctrl.regWrite = ctrl.regWrite && (dst != '0);
	end

	// Condition on the committed flags
	always_comb begin
		case (cond_e'(ifId.instr[11:9]))
			CondNe: condTrue = !flags.z;
			CondEq: condTrue = flags.z;
			CondGt: condTrue = !flags.z && !flags.n;
			CondLt: condTrue = flags.n;
			CondGe: condTrue = flags.z || !flags.n;
			CondLe: condTrue = flags.n || flags.z;
			CondOv: condTrue = flags.v;
			default: condTrue = 1'b1;
		endcase
	end

	assign isBranch = (op == OpB) && (ifId.instr != '0);
	assign haltSeen = (op == OpHlt);
	assign branchTarget = ifId.pcPlus1 + {{(DataWidth-9){ifId.instr[8]}}, ifId.instr[8:0]};
	// Held off while the flags are still in flight
	assign branchTaken = isBranch && condTrue && !hazardStall;

	always_comb begin
		idExNext = '{ctrl: ctrl, opA: readReg(srcA), opB: readReg(srcB),
			srcA: srcA, srcB: srcB, dst: dst, imm: imm};
	end

	// Bubble into EX on a hazard stall
	pipeReg #(.payload_t(idEx_t)) u_idExReg (
		.clk  (clk),
		.rstN (rstN),
		.en   (!memStall),
		.flush(hazardStall),
		.d    (idExNext),
		.q    (idEx)
	);

	// Writeback from MEM/WB never names r0
	wbNotR0: assert property (@(posedge clk) disable iff (!rstN) wbEn |-> wbReg != '0);

endmodule

// File: hazardForward.sv
`timescale 1ns/1ps

module hazardForward import cpuPkg::*; (
	input  regAddr_t srcA,
	input  regAddr_t srcB,
	input  logic     isBranch,
	input  idEx_t    idEx,
	input  exMem_t   exMem,
	input  logic     wbEn,
	input  regAddr_t wbReg,
	output logic     hazardStall,
	output fwdSel_e  fwdA,
	output fwdSel_e  fwdB
);

	logic loadUse;
	logic flagUse;

	// regWrite is already cleared for r0 targets
	assign loadUse = idEx.ctrl.memRead && idEx.ctrl.regWrite &&
		(srcA == idEx.dst || srcB == idEx.dst);
	// Branch must see flags of the ALU op ahead of it
	assign flagUse = isBranch && idEx.ctrl.setsFlags;
	assign hazardStall = loadUse || flagUse;

	// Youngest producer first, loads in MEM have no data yet
	function automatic fwdSel_e pickFwd(regAddr_t src);
		fwdSel_e sel;
		sel = FwdNone;
		if (src != '0) begin
			if (exMem.ctrl.regWrite && !exMem.ctrl.memRead && exMem.dst == src) begin
				sel = FwdMem;
			end else if (wbEn && wbReg == src) begin
				sel = FwdWb;
			end
		end
		return sel;
	endfunction

	always_comb begin
		fwdA = pickFwd(idEx.srcA);
		fwdB = pickFwd(idEx.srcB);
	end

endmodule

// File: executeStage.sv
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
	input  logic    clk,
	input  logic    rstN,
	input  idEx_t   idEx,
	input  fwdSel_e fwdA,
	input  fwdSel_e fwdB,
	input  logic    memStall,
	input  word_t   wbData,
	output flags_t  flags,
	output exMem_t  exMem
);

	word_t opA;
	word_t opB;
	word_t addend;
	word_t sum;
	word_t diff;
	word_t result;
	logic overflow;
	flags_t nextFlags;
	exMem_t exMemNext;

	// Operand forwarding
	always_comb begin
		case (fwdA)
			FwdMem: opA = exMem.aluResult;
			FwdWb: opA = wbData;
			default: opA = idEx.opA;
		endcase
		case (fwdB)
			FwdMem: opB = exMem.aluResult;
			FwdWb: opB = wbData;
			default: opB = idEx.opB;
		endcase
	end

	// Memory ops add the offset to the base
	assign addend = (idEx.ctrl.memRead || idEx.ctrl.memWrite) ? idEx.imm : opB;
	assign sum = opA + addend;
	assign diff = opA - opB;

	always_comb begin
		case (idEx.ctrl.aluOp)
			AluSub: result = diff;
			AluXor: result = opA ^ opB;
			AluByte: result = idEx.ctrl.loadHigh ? {idEx.imm[7:0], opB[7:0]} :
				{opB[15:8], idEx.imm[7:0]};
			default: result = sum;
		endcase
	end

	// Signed overflow for ADD and SUB
	assign overflow = (idEx.ctrl.aluOp == AluSub) ?
		(opA[DataWidth-1] != opB[DataWidth-1]) && (diff[DataWidth-1] != opA[DataWidth-1]) :
		(opA[DataWidth-1] == addend[DataWidth-1]) && (sum[DataWidth-1] != opA[DataWidth-1]);

	// XOR leaves N and V alone
	always_comb begin
		nextFlags = flags;
		nextFlags.z = (result == '0);
		if (idEx.ctrl.aluOp != AluXor) begin
			nextFlags.n = result[DataWidth-1];
			nextFlags.v = overflow;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			flags <= '0;
		end else if (idEx.ctrl.setsFlags && !memStall) begin
			flags <= nextFlags;
		end
	end

	assign exMemNext = '{ctrl: idEx.ctrl, aluResult: result, storeData: opB, dst: idEx.dst};

	pipeReg #(.payload_t(exMem_t)) u_exMemReg (
		.clk  (clk),
		.rstN (rstN),
		.en   (!memStall),
		.flush(1'b0),
		.d    (exMemNext),
		.q    (exMem)
	);

endmodule

// File: memoryStage.sv
`timescale 1ns/1ps

module memoryStage import cpuPkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  exMem_t   exMem,
	output apbReq_t  apbReq,
	input  apbRsp_t  apbRsp,
	output logic     memStall,
	output logic     wbEn,
	output regAddr_t wbReg,
	output word_t    wbData,
	output logic     hlt
);

	logic memOp;
	// Low in setup, high in access
	logic inAccess;
	logic hltSticky;
	memWb_t memWbNext;
	memWb_t memWb;

	assign memOp = exMem.ctrl.memRead || exMem.ctrl.memWrite;

	// Setup always lasts one cycle
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			inAccess <= 1'b0;
		end else if (!inAccess) begin
			inAccess <= memOp;
		end else if (apbRsp.pready) begin
			inAccess <= 1'b0;
		end
	end

	// EX/MEM is frozen during the transfer so these hold
	always_comb begin
		apbReq.psel = memOp;
		apbReq.penable = inAccess;
		apbReq.pwrite = exMem.ctrl.memWrite;
		apbReq.paddr = exMem.aluResult;
		apbReq.pwdata = exMem.storeData;
	end

	// Released only on the completing access cycle
	assign memStall = memOp && !(inAccess && apbRsp.pready);

	assign memWbNext = '{regWrite: exMem.ctrl.regWrite, hlt: exMem.ctrl.hlt,
		memRead: exMem.ctrl.memRead, aluResult: exMem.aluResult,
		readData: apbRsp.prdata, dst: exMem.dst};

	pipeReg #(.payload_t(memWb_t)) u_memWbReg (
		.clk  (clk),
		.rstN (rstN),
		.en   (!memStall),
		.flush(1'b0),
		.d    (memWbNext),
		.q    (memWb)
	);

	// Writeback select
	assign wbEn = memWb.regWrite;
	assign wbReg = memWb.dst;
	assign wbData = memWb.memRead ? memWb.readData : memWb.aluResult;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			hltSticky <= 1'b0;
		end else if (memWb.hlt) begin
			hltSticky <= 1'b1;
		end
	end

	// High from the cycle HLT sits in WB
	assign hlt = hltSticky || memWb.hlt;

	// Setup is followed by access
	apbSetup: assert property (@(posedge clk) disable iff (!rstN)
		apbReq.psel && !apbReq.penable |=> apbReq.psel && apbReq.penable);

	// Request fields hold through wait states
	apbStable: assert property (@(posedge clk) disable iff (!rstN)
		apbReq.penable && !apbRsp.pready |=>
			$stable(apbReq.paddr) && $stable(apbReq.pwrite) && $stable(apbReq.pwdata));

endmodule

// File: cpu.sv
`timescale 1ns/1ps

module cpu import cpuPkg::*; #(
	parameter word_t ResetPc = '0
) (
	input  logic    clk,
	input  logic    rstN,
	output word_t   pc,
	input  word_t   instr,
	output logic    hlt,
	output apbReq_t apbReq,
	input  apbRsp_t apbRsp
);

	// Stage boundaries
	ifId_t ifId;
	idEx_t idEx;
	exMem_t exMem;

	// Branch and halt from ID
	logic branchTaken;
	word_t branchTarget;
	logic haltSeen;
	logic isBranch;

	// Hazard and forwarding
	regAddr_t srcA;
	regAddr_t srcB;
	logic hazardStall;
	logic memStall;
	fwdSel_e fwdA;
	fwdSel_e fwdB;
	flags_t flags;

	// Writeback port
	logic wbEn;
	regAddr_t wbReg;
	word_t wbData;

	fetchStage #(.ResetPc(ResetPc)) u_fetch (
		.clk         (clk),
		.rstN        (rstN),
		.instr       (instr),
		.pc          (pc),
		.branchTaken (branchTaken),
		.branchTarget(branchTarget),
		.hazardStall (hazardStall),
		.memStall    (memStall),
		.haltSeen    (haltSeen),
		.ifId        (ifId)
	);

	decodeStage u_decode (
		.clk         (clk),
		.rstN        (rstN),
		.ifId        (ifId),
		.flags       (flags),
		.hazardStall (hazardStall),
		.memStall    (memStall),
		.wbEn        (wbEn),
		.wbReg       (wbReg),
		.wbData      (wbData),
		.srcA        (srcA),
		.srcB        (srcB),
		.isBranch    (isBranch),
		.branchTaken (branchTaken),
		.branchTarget(branchTarget),
		.haltSeen    (haltSeen),
		.idEx        (idEx)
	);

	hazardForward u_hazard (
		.srcA       (srcA),
		.srcB       (srcB),
		.isBranch   (isBranch),
		.idEx       (idEx),
		.exMem      (exMem),
		.wbEn       (wbEn),
		.wbReg      (wbReg),
		.hazardStall(hazardStall),
		.fwdA       (fwdA),
		.fwdB       (fwdB)
	);

	executeStage u_execute (
		.clk     (clk),
		.rstN    (rstN),
		.idEx    (idEx),
		.fwdA    (fwdA),
		.fwdB    (fwdB),
		.memStall(memStall),
		.wbData  (wbData),
		.flags   (flags),
		.exMem   (exMem)
	);

	memoryStage u_memory (
		.clk     (clk),
		.rstN    (rstN),
		.exMem   (exMem),
		.apbReq  (apbReq),
		.apbRsp  (apbRsp),
		.memStall(memStall),
		.wbEn    (wbEn),
		.wbReg   (wbReg),
		.wbData  (wbData),
		.hlt     (hlt)
	);

endmodule

// File: cpuTb.sv
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();

	localparam int HltTimeout = 3000;
	localparam logic [15:0] HltWord = 16'hF000;

	logic clk;
	logic rstN;
	word_t pc;
	word_t instr;
	logic hlt;
	apbReq_t apbReq;
	apbRsp_t apbRsp;

	// Random source state
	logic [31:0] lfsrState;

	// Instruction ROM, unused words hold HLT
	logic [15:0] prog [256];
	logic [15:0] dataMem [256];
	int progLen;

	// ISA model state and its expected stores
	logic [15:0] modelRegs [16];
	logic [15:0] modelMem [256];
	logic [15:0] expStoreAddr [$];
	logic [15:0] expStoreData [$];
	int haltAddr;

	// APB slave bookkeeping
	int writeCount;
	int setupCycles;
	int waitLeft;

	cpu #(.ResetPc('0)) u_dut (
		.clk   (clk),
		.rstN  (rstN),
		.pc    (pc),
		.instr (instr),
		.hlt   (hlt),
		.apbReq(apbReq),
		.apbRsp(apbRsp)
	);

	always #50 clk = ~clk;

	// Asynchronous instruction read
	assign instr = prog[pc[7:0]];

	// One LFSR step per returned bit
	function automatic logic [31:0] randBits(input int count);
		logic [31:0] value;
		logic bitOut;
		int k;
		value = '0;
		for (k = 0; k < count; k++) begin
			bitOut = lfsrState[0];
			lfsrState = lfsrState >> 1;
			if (bitOut) begin
				lfsrState = lfsrState ^ 32'hA300_0000;
			end
			value = {value[30:0], bitOut};
		end
		return value;
	endfunction

	task automatic abortRun();
		$display("Checks failed");
		$fatal(1, "Simulation stopped on the first failure");
	endtask

	task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("** Error @ %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
			abortRun();
		end
	endtask

	// Forward only, never past the HLT at the end
	function automatic logic [15:0] branchWord(input int at);
		logic [2:0] cond;
		logic [8:0] off;
		cond = randBits(3);
		off = randBits(3) % (progLen - 1 - at);
		return {4'd12, cond, off};
	endfunction

	task automatic buildProgram();
		int i;
		int a;
		int pick;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
		logic [3:0] opc;
		logic [3:0] ofs;
		logic [7:0] imm8;
		progLen = 40 + randBits(5) % 21;
		for (a = 0; a < 256; a++) begin
			prog[a] = HltWord;
		end
		i = 0;
		while (i < progLen - 1) begin
			// Only r1..r7 as targets, so dependencies are frequent
			rd = randBits(3);
			if (rd == 0) begin
				rd = 1;
			end
			rs = randBits(3);
			rt = randBits(3);
			ofs = randBits(4);
			pick = randBits(4);
			if (pick < 5) begin
				opc = randBits(2);
				if (opc == 3) begin
					opc = 1;
				end
				prog[i] = {opc, rd, rs, rt};
				i++;
				// Flag producer right before a branch
				if (i < progLen - 1 && randBits(1)) begin
					prog[i] = branchWord(i);
					i++;
				end
			end else if (pick < 8) begin
				imm8 = randBits(8);
				prog[i] = {(pick == 7) ? 4'd11 : 4'd10, rd, imm8};
				i++;
			end else if (pick < 10) begin
				prog[i] = {4'd8, rd, rs, ofs};
				i++;
				// Loaded value stored at once
				if (i < progLen - 1 && randBits(1)) begin
					ofs = randBits(4);
					prog[i] = {4'd9, rd, rt, ofs};
					i++;
				end
			end else if (pick < 13) begin
				prog[i] = {4'd9, rd, rs, ofs};
				i++;
			end else begin
				prog[i] = branchWord(i);
				i++;
			end
		end
		for (a = 0; a < 256; a++) begin
			dataMem[a] = randBits(16);
		end
	endtask

	// Instruction by instruction, no pipeline
	task automatic runModel();
		int mpc;
		int steps;
		int k;
		logic [15:0] word;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic [15:0] addr;
		logic [3:0] rd;
		logic taken;
		logic fn;
		logic fv;
		logic fz;
		for (k = 0; k < 16; k++) begin
			modelRegs[k] = '0;
		end
		for (k = 0; k < 256; k++) begin
			modelMem[k] = dataMem[k];
		end
		fn = 1'b0;
		fv = 1'b0;
		fz = 1'b0;
		mpc = 0;
		steps = 0;
		haltAddr = -1;
		while (haltAddr < 0) begin
			if (steps > 4096) begin
				$display("ISA model ran past %0d steps without reaching HLT", steps);
				abortRun();
			end
			steps++;
			word = prog[mpc];
			rd = word[11:8];
			a = modelRegs[word[7:4]];
			b = modelRegs[word[3:0]];
			addr = a + {{12{word[3]}}, word[3:0]};
			case (word[15:12])
				4'd0, 4'd1: begin
					res = (word[15:12] == 4'd0) ? a + b : a - b;
					if (word[15:12] == 4'd0) begin
						fv = (a[15] == b[15]) && (res[15] != a[15]);
					end else begin
						fv = (a[15] != b[15]) && (res[15] != a[15]);
					end
					fn = res[15];
					fz = (res == 16'd0);
					modelRegs[rd] = res;
				end
				4'd2: begin
					// Z only
					res = a ^ b;
					fz = (res == 16'd0);
					modelRegs[rd] = res;
				end
				4'd8: modelRegs[rd] = modelMem[addr[7:0]];
				4'd9: begin
					expStoreAddr.push_back(addr);
					expStoreData.push_back(modelRegs[rd]);
					modelMem[addr[7:0]] = modelRegs[rd];
				end
				4'd10: modelRegs[rd][7:0] = word[7:0];
				4'd11: modelRegs[rd][15:8] = word[7:0];
				4'd12: begin
					case (word[11:9])
						3'd0: taken = !fz;
						3'd1: taken = fz;
						3'd2: taken = !fz && !fn;
						3'd3: taken = fn;
						3'd4: taken = fz || !fn;
						3'd5: taken = fn || fz;
						3'd6: taken = fv;
						default: taken = 1'b1;
					endcase
					if (taken) begin
						mpc = mpc + $signed(word[8:0]);
					end
				end
				4'd15: haltAddr = mpc;
				default: ;
			endcase
			modelRegs[0] = '0;
			mpc++;
		end
	endtask

	// APB slave with 0 to 3 wait states
	// Request is looked at once it has settled after the edge
	always @(posedge clk) begin
		logic ready;
		#10;
		ready = 1'b0;
		if (rstN) begin
			if (hlt && apbReq.psel) begin
				$display("APB transfer seen at %0t after hlt went high", $time);
				abortRun();
			end
			if (apbReq.psel && !apbReq.penable) begin
				setupCycles++;
				waitLeft = randBits(2);
			end else if (apbReq.psel && apbReq.penable) begin
				checkEqual(setupCycles, 1, "setup cycles before APB access");
				if (waitLeft == 0) begin
					ready = 1'b1;
					if (apbReq.pwrite) begin
						if (writeCount >= expStoreAddr.size()) begin
							$display("APB write at %0t has no matching store in the ISA model",
								$time);
							abortRun();
						end
						checkEqual(apbReq.paddr, expStoreAddr[writeCount], "store address");
						checkEqual(apbReq.pwdata, expStoreData[writeCount], "store data");
						dataMem[apbReq.paddr[7:0]] = apbReq.pwdata;
						writeCount++;
					end
					setupCycles = 0;
				end else begin
					waitLeft--;
				end
			end
		end
		apbRsp.pready = ready;
		apbRsp.prdata = dataMem[apbReq.paddr[7:0]];
	end

	initial begin
		int cycles;
		clk = 1'b0;
		rstN = 1'b0;
		apbRsp = '0;
		lfsrState = 32'hf09f_2e62;
		writeCount = 0;
		setupCycles = 0;
		waitLeft = 0;
		buildProgram();
		runModel();
		$display("Program of %0d words, %0d stores expected, HLT at %0d",
			progLen, expStoreAddr.size(), haltAddr);
		repeat (2) @(posedge clk);
		#10;
		rstN = 1'b1;
		cycles = 0;
		while (!hlt) begin
			@(negedge clk);
			cycles++;
			if (cycles > HltTimeout) begin
				$display("Timeout: hlt did not rise within %0d cycles", HltTimeout);
				abortRun();
			end
		end
		// Halted core stays frozen
		repeat (8) begin
			@(negedge clk);
			checkEqual(hlt, 1'b1, "hlt held high");
		end
		checkEqual(pc, haltAddr + 1, "pc after halt");
		checkEqual(writeCount, expStoreAddr.size(), "number of APB writes");
		$display("All checks passed");
		$finish;
	end

endmodule

// File: all.f
cpuPkg.sv
pipeReg.sv
fetchStage.sv
decodeStage.sv
hazardForward.sv
executeStage.sv
memoryStage.sv
cpu.sv
cpuTb.sv

// File: Bender.yml
package:
  name: wisc_cpu

sources:
  - cpuPkg.sv
  - pipeReg.sv
  - fetchStage.sv
  - decodeStage.sv
  - hazardForward.sv
  - executeStage.sv
  - memoryStage.sv
  - cpu.sv
  - target: test
    files:
      - cpuTb.sv
